// ==== cache_axi_pkg.sv ====
`default_nettype none

package cache_axi_pkg;

    // transaction ids on the axi side
    localparam logic [3:0] ID_ICACHE = 4'd0;
    localparam logic [3:0] ID_DCACHE = 4'd1;

    localparam logic [2:0] TYPE_LINE = 3'd4;   // 0..2 are byte/half/word sizes
    localparam int LINE_BEATS = 4;

    typedef struct packed {
        logic [2:0]  rtype;
        logic [31:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic [2:0]   rtype;
        logic [31:0]  addr;
        logic [3:0]   strb;
        logic [127:0] data;   // word 0 in the low bits
    } wr_req_t;

    typedef struct packed {
        logic        last;
        logic [31:0] data;
    } ret_t;

    // also used for the write address channel
    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [2:0]  size;
    } axi_ar_t;

    typedef struct packed {
        logic [3:0]  id;
        logic [31:0] data;
        logic        last;
    } axi_r_t;

    typedef struct packed {
        logic [31:0] data;
        logic [3:0]  strb;
        logic        last;
    } axi_w_t;

    function automatic logic [7:0] burst_len(input logic [2:0] rtype);
        return (rtype == TYPE_LINE) ? 8'(LINE_BEATS - 1) : 8'd0;
    endfunction

    // a line goes out as word beats
    function automatic logic [2:0] burst_size(input logic [2:0] rtype);
        return (rtype == TYPE_LINE) ? 3'd2 : rtype;
    endfunction

endpackage

`default_nettype wire

// ==== bridge_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridge_ctrl (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_ird_req,
    input  wire cache_axi_pkg::rd_req_t i_ird,
    input  wire logic                   i_drd_req,
    input  wire cache_axi_pkg::rd_req_t i_drd,
    input  wire logic                   i_wr_busy,
    input  wire logic                   i_ar_free,
    output logic                        o_ld,
    output cache_axi_pkg::rd_req_t      o_ld_req,
    output logic [3:0]                  o_ld_id,
    output logic                        o_ird_rdy,
    output logic                        o_drd_rdy
);

    logic pend_q;     // a read is parked behind a write
    logic pend_d_q;   // which client it was
    logic any_req;
    logic want_d;
    logic sel_req;

    assign any_req = i_ird_req || i_drd_req;

    // data cache has priority unless a parked client is waiting
    assign want_d = pend_q ? pend_d_q : i_drd_req;
    assign sel_req = want_d ? i_drd_req : i_ird_req;

    assign o_ld = sel_req && i_ar_free && !i_wr_busy;
    assign o_ld_req = want_d ? i_drd : i_ird;
    assign o_ld_id = want_d ? cache_axi_pkg::ID_DCACHE : cache_axi_pkg::ID_ICACHE;

    assign o_drd_rdy = o_ld && want_d;
    assign o_ird_rdy = o_ld && !want_d;

    // the stalled client keeps its grant once the write drains,
    // so a later request cannot get ahead of it
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            pend_q <= 1'b0;
            pend_d_q <= 1'b0;
        end else if (o_ld) begin
            pend_q <= 1'b0;
        end else if (!pend_q && any_req && i_wr_busy) begin
            pend_q <= 1'b1;
            pend_d_q <= i_drd_req;
        end
    end

endmodule

`default_nettype wire

// ==== rd_addr_issue.sv ====
`timescale 1ns/1ps
`default_nettype none

module rd_addr_issue (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_ld,
    input  wire cache_axi_pkg::rd_req_t i_ld_req,
    input  wire logic [3:0]             i_ld_id,
    input  wire logic                   i_arready,
    output logic                        o_arvalid,
    output cache_axi_pkg::axi_ar_t      o_ar,
    output logic                        o_free
);

    // free now, or free once this handshake completes
    assign o_free = !o_arvalid || i_arready;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            o_arvalid <= 1'b0;
        end else if (i_ld) begin
            o_arvalid <= 1'b1;
        end else if (i_arready) begin
            o_arvalid <= 1'b0;
        end
    end

    // address register, only loaded when free
    always_ff @(posedge i_clock) begin
        if (i_ld) begin
            o_ar.id <= i_ld_id;
            o_ar.addr <= i_ld_req.addr;
            o_ar.len <= cache_axi_pkg::burst_len(i_ld_req.rtype);
            o_ar.size <= cache_axi_pkg::burst_size(i_ld_req.rtype);
        end
    end

endmodule

`default_nettype wire

// ==== rd_return_route.sv ====
`timescale 1ns/1ps
`default_nettype none

module rd_return_route (
    input  wire logic                  i_rvalid,
    input  wire cache_axi_pkg::axi_r_t i_r,
    output logic                       o_iret_valid,
    output cache_axi_pkg::ret_t        o_iret,
    output logic                       o_dret_valid,
    output cache_axi_pkg::ret_t        o_dret
);

    logic to_dcache;

    assign to_dcache = (i_r.id == cache_axi_pkg::ID_DCACHE);

    assign o_iret_valid = i_rvalid && !to_dcache;
    assign o_dret_valid = i_rvalid && to_dcache;

    // payload goes to both, valid decides
    assign o_iret.last = i_r.last;
    assign o_iret.data = i_r.data;
    assign o_dret.last = i_r.last;
    assign o_dret.data = i_r.data;

endmodule

`default_nettype wire

// ==== wr_burst_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module wr_burst_unit (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_dwr_req,
    input  wire cache_axi_pkg::wr_req_t i_dwr,
    input  wire logic                   i_awready,
    input  wire logic                   i_wready,
    input  wire logic                   i_bvalid,
    output logic                        o_awvalid,
    output cache_axi_pkg::axi_ar_t      o_aw,
    output logic                        o_wvalid,
    output cache_axi_pkg::axi_w_t       o_w,
    output logic                        o_bready,
    output logic                        o_dwr_rdy,
    output logic                        o_busy
);

    localparam int CW = $clog2(cache_axi_pkg::LINE_BEATS);

    typedef enum logic [1:0] {
        s_idle,
        s_send,
        s_resp
    } state_t;

    state_t state_q;

    logic [cache_axi_pkg::LINE_BEATS-1:0][31:0] line_q;
    logic [3:0]    strb_q;
    logic [CW-1:0] cnt_q;    // current beat
    logic [CW-1:0] final_q;  // index of the last beat
    logic          aw_hs;
    logic          w_hs;
    logic [7:0]    req_len;

    // address straight from the request while idle
    assign o_awvalid = (state_q == s_idle) && i_dwr_req;
    assign req_len = cache_axi_pkg::burst_len(i_dwr.rtype);
    assign o_aw.id = cache_axi_pkg::ID_DCACHE;
    assign o_aw.addr = i_dwr.addr;
    assign o_aw.len = req_len;
    assign o_aw.size = cache_axi_pkg::burst_size(i_dwr.rtype);

    assign aw_hs = o_awvalid && i_awready;
    assign o_dwr_rdy = aw_hs;

    assign o_wvalid = (state_q == s_send);
    assign o_w.data = line_q[cnt_q];
    assign o_w.strb = strb_q;
    assign o_w.last = (cnt_q == final_q);
    assign w_hs = o_wvalid && i_wready;

    assign o_bready = (state_q == s_resp);
    assign o_busy = (state_q != s_idle);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state_q <= s_idle;
        end else begin
            case (state_q)
                s_idle: begin
                    if (aw_hs) state_q <= s_send;
                end
                s_send: begin
                    if (w_hs && o_w.last) state_q <= s_resp;
                end
                s_resp: begin
                    if (i_bvalid) state_q <= s_idle;
                end
                default: state_q <= s_idle;
            endcase
        end
    end

    // line buffer and beat counter
    always_ff @(posedge i_clock) begin
        if (aw_hs) begin
            line_q <= i_dwr.data;
            strb_q <= i_dwr.strb;
            final_q <= req_len[CW-1:0];
            cnt_q <= '0;
        end else if (w_hs) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== axi_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
    parameter int MEM_WORDS = 256
) (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_arvalid,
    input  wire cache_axi_pkg::axi_ar_t i_ar,
    output logic                        o_arready,
    output logic                        o_rvalid,
    output cache_axi_pkg::axi_r_t       o_r,
    input  wire logic                   i_awvalid,
    input  wire cache_axi_pkg::axi_ar_t i_aw,
    output logic                        o_awready,
    input  wire logic                   i_wvalid,
    input  wire cache_axi_pkg::axi_w_t  i_w,
    output logic                        o_wready,
    output logic                        o_bvalid,
    input  wire logic                   i_bready
);

    localparam int AW = $clog2(MEM_WORDS);

    typedef enum logic [2:0] {
        m_idle,
        m_ar_ack,
        m_rd_wait,
        m_rd_data,
        m_aw_ack,
        m_wr_data,
        m_wr_resp
    } mstate_t;

    mstate_t state_q;

    logic [31:0]   mem [MEM_WORDS];
    logic [AW-1:0] addr_q;   // word index
    logic [7:0]    beat_q;
    logic [7:0]    len_q;
    logic [3:0]    id_q;
    logic          rd_last;

    assign rd_last = (beat_q == len_q);

    assign o_arready = (state_q == m_ar_ack);
    assign o_awready = (state_q == m_aw_ack);
    assign o_wready = (state_q == m_wr_data);
    assign o_rvalid = (state_q == m_rd_data);
    assign o_bvalid = (state_q == m_wr_resp);

    assign o_r.id = id_q;
    assign o_r.data = mem[addr_q];
    assign o_r.last = rd_last;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state_q <= m_idle;
        end else begin
            case (state_q)
                m_idle: begin
                    if (i_arvalid) begin          // reads first
                        state_q <= m_ar_ack;
                    end else if (i_awvalid) begin
                        state_q <= m_aw_ack;
                    end
                end
                m_ar_ack:  state_q <= m_rd_wait;
                m_rd_wait: state_q <= m_rd_data;
                m_rd_data: begin
                    if (rd_last) state_q <= m_idle;
                end
                m_aw_ack:  state_q <= m_wr_data;
                m_wr_data: begin
                    if (i_wvalid && i_w.last) state_q <= m_wr_resp;
                end
                m_wr_resp: begin
                    if (i_bready) state_q <= m_idle;
                end
                default: state_q <= m_idle;
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            // each word holds its own index in every byte
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= {4{8'(i)}};
            end
        end else begin
            case (state_q)
                m_ar_ack: begin
                    addr_q <= i_ar.addr[AW+1:2];
                    len_q <= i_ar.len;
                    id_q <= i_ar.id;
                    beat_q <= '0;
                end
                m_rd_data: begin
                    beat_q <= beat_q + 8'd1;
                    addr_q <= addr_q + 1'b1;
                end
                m_aw_ack: addr_q <= i_aw.addr[AW+1:2];
                m_wr_data: begin
                    if (i_wvalid) begin
                        for (int b = 0; b < 4; b++) begin
                            if (i_w.strb[b]) mem[addr_q][8*b +: 8] <= i_w.data[8*b +: 8];
                        end
                        addr_q <= addr_q + 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== cache_mem_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_mem_top #(
    parameter int MEM_WORDS = 256
) (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_ird_req,
    input  wire cache_axi_pkg::rd_req_t i_ird,
    output logic                        o_ird_rdy,
    input  wire logic                   i_drd_req,
    input  wire cache_axi_pkg::rd_req_t i_drd,
    output logic                        o_drd_rdy,
    input  wire logic                   i_dwr_req,
    input  wire cache_axi_pkg::wr_req_t i_dwr,
    output logic                        o_dwr_rdy,
    output logic                        o_iret_valid,
    output cache_axi_pkg::ret_t         o_iret,
    output logic                        o_dret_valid,
    output cache_axi_pkg::ret_t         o_dret
);

    logic                   ld;
    cache_axi_pkg::rd_req_t ld_req;
    logic [3:0]             ld_id;
    logic                   ar_free;
    logic                   wr_busy;

    // internal axi
    logic                   arvalid, arready;
    cache_axi_pkg::axi_ar_t ar;
    logic                   rvalid;
    cache_axi_pkg::axi_r_t  r;
    logic                   awvalid, awready;
    cache_axi_pkg::axi_ar_t aw;
    logic                   wvalid, wready;
    cache_axi_pkg::axi_w_t  w;
    logic                   bvalid, bready;

    bridge_ctrl u_ctrl (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_ird_req (i_ird_req),
        .i_ird     (i_ird),
        .i_drd_req (i_drd_req),
        .i_drd     (i_drd),
        .i_wr_busy (wr_busy),
        .i_ar_free (ar_free),
        .o_ld      (ld),
        .o_ld_req  (ld_req),
        .o_ld_id   (ld_id),
        .o_ird_rdy (o_ird_rdy),
        .o_drd_rdy (o_drd_rdy)
    );

    rd_addr_issue u_rd_addr (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_ld      (ld),
        .i_ld_req  (ld_req),
        .i_ld_id   (ld_id),
        .i_arready (arready),
        .o_arvalid (arvalid),
        .o_ar      (ar),
        .o_free    (ar_free)
    );

    rd_return_route u_rd_ret (
        .i_rvalid     (rvalid),
        .i_r          (r),
        .o_iret_valid (o_iret_valid),
        .o_iret       (o_iret),
        .o_dret_valid (o_dret_valid),
        .o_dret       (o_dret)
    );

    wr_burst_unit u_wr (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_dwr_req (i_dwr_req),
        .i_dwr     (i_dwr),
        .i_awready (awready),
        .i_wready  (wready),
        .i_bvalid  (bvalid),
        .o_awvalid (awvalid),
        .o_aw      (aw),
        .o_wvalid  (wvalid),
        .o_w       (w),
        .o_bready  (bready),
        .o_dwr_rdy (o_dwr_rdy),
        .o_busy    (wr_busy)
    );

    axi_mem_model #(
        .MEM_WORDS (MEM_WORDS)
    ) u_mem (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_arvalid (arvalid),
        .i_ar      (ar),
        .o_arready (arready),
        .o_rvalid  (rvalid),
        .o_r       (r),
        .i_awvalid (awvalid),
        .i_aw      (aw),
        .o_awready (awready),
        .i_wvalid  (wvalid),
        .i_w       (w),
        .o_wready  (wready),
        .o_bvalid  (bvalid),
        .i_bready  (bready)
    );

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
    parameter int MEM_WORDS = 256
) (
    input  wire logic                   i_clock,
    input  wire logic                   i_reset,
    input  wire logic                   i_ird_req,
    input  wire cache_axi_pkg::rd_req_t i_ird,
    input  wire logic                   i_ird_rdy,
    input  wire logic                   i_drd_req,
    input  wire cache_axi_pkg::rd_req_t i_drd,
    input  wire logic                   i_drd_rdy,
    input  wire logic                   i_dwr_req,
    input  wire cache_axi_pkg::wr_req_t i_dwr,
    input  wire logic                   i_dwr_rdy,
    input  wire logic                   i_iret_valid,
    input  wire cache_axi_pkg::ret_t    i_iret,
    input  wire logic                   i_dret_valid,
    input  wire cache_axi_pkg::ret_t    i_dret,
    input  wire logic                   i_test_done,
    input  wire logic [7:0]             i_test_idx,
    output int                          o_pending,
    output int                          o_checks,
    output int                          o_errors
);

    logic [31:0]         model [MEM_WORDS];
    cache_axi_pkg::ret_t iexp_q [$];   // beats still owed to each cache
    cache_axi_pkg::ret_t dexp_q [$];
    int cycle = 0;
    int wr_cycle;
    int wr_beats;
    int checks = 0;
    int errors = 0;
    int test_errors = 0;

    function automatic int beats_of(input logic [2:0] rtype);
        return (rtype == cache_axi_pkg::TYPE_LINE) ? cache_axi_pkg::LINE_BEATS : 1;
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic check_beat(input string port, input cache_axi_pkg::ret_t exp,
                              input cache_axi_pkg::ret_t got);
        checks++;
        if (got.data !== exp.data) begin
            report_error($sformatf("mismatch %s.data expected %h got %h",
                                   port, exp.data, got.data));
        end
        if (got.last !== exp.last) begin
            report_error($sformatf("mismatch %s.last expected %h got %h",
                                   port, exp.last, got.last));
        end
    endtask

    task automatic predict(input logic to_d, input cache_axi_pkg::rd_req_t req);
        int n;
        int base;
        cache_axi_pkg::ret_t beat;
        n = beats_of(req.rtype);
        base = int'(req.addr[31:2]);
        for (int k = 0; k < n; k++) begin
            beat.data = model[(base + k) % MEM_WORDS];
            beat.last = (k == n - 1);
            if (to_d) dexp_q.push_back(beat);
            else iexp_q.push_back(beat);
        end
    endtask

    task automatic write_model(input cache_axi_pkg::wr_req_t wr);
        int base;
        int idx;
        base = int'(wr.addr[31:2]);
        wr_beats = beats_of(wr.rtype);
        wr_cycle = cycle;
        for (int k = 0; k < wr_beats; k++) begin
            idx = (base + k) % MEM_WORDS;
            for (int b = 0; b < 4; b++) begin
                if (wr.strb[b]) model[idx][8*b +: 8] = wr.data[32*k + 8*b +: 8];
            end
        end
    endtask

    // the write owns the bus until its response, two cycles past the last beat
    task automatic check_order();
        if (cycle - wr_cycle <= wr_beats + 1) begin
            report_error("read accepted while a write was still in progress");
        end
    endtask

    always @(posedge i_clock) begin
        cycle++;
        if (i_reset) begin
            for (int i = 0; i < MEM_WORDS; i++) model[i] = {4{8'(i)}};
            iexp_q.delete();
            dexp_q.delete();
            wr_cycle = -1000;
            wr_beats = 0;
        end else begin
            if (i_dwr_req && i_dwr_rdy) write_model(i_dwr);
            if (i_drd_req && i_drd_rdy) begin
                check_order();
                predict(1'b1, i_drd);
            end
            if (i_ird_req && i_ird_rdy) begin
                if (i_drd_req) report_error("instruction read accepted ahead of a data read");
                check_order();
                predict(1'b0, i_ird);
            end
            if (i_iret_valid) begin
                if (iexp_q.size() == 0) report_error("extra return beat on the icache port");
                else check_beat("o_iret", iexp_q.pop_front(), i_iret);
            end
            if (i_dret_valid) begin
                if (dexp_q.size() == 0) report_error("extra return beat on the dcache port");
                else check_beat("o_dret", dexp_q.pop_front(), i_dret);
            end
            if (i_test_done) begin
                if (test_errors == 0) $display("test %0d passed", i_test_idx);
                else $display("test %0d failed with %0d errors", i_test_idx, test_errors);
                test_errors = 0;
            end
        end
        o_pending <= iexp_q.size() + dexp_q.size();
        o_checks <= checks;
        o_errors <= errors;
    end

endmodule

`default_nettype wire

// ==== tb_cache_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_mem;

    localparam int MEM_WORDS = 256;
    localparam int NUM_ROWS = 10;
    localparam int MAX_CYCLES = NUM_ROWS * 40;

    localparam logic [1:0] ICACHE = 2'd0;
    localparam logic [1:0] DCACHE = 2'd1;
    localparam logic [1:0] BOTH = 2'd2;    // both caches read in the same cycle
    localparam logic [2:0] WORD = 3'd2;
    localparam logic [2:0] LINE = 3'd4;

    typedef struct packed {
        logic [1:0]   client;
        logic         write;
        logic [2:0]   rtype;
        logic [31:0]  addr;
        logic [31:0]  iaddr;   // icache word of a paired read
        logic [3:0]   strb;
        logic [127:0] data;
    } test_row_t;

    logic                   clock;
    logic                   reset;
    logic                   ird_req;
    cache_axi_pkg::rd_req_t ird;
    logic                   ird_rdy;
    logic                   drd_req;
    cache_axi_pkg::rd_req_t drd;
    logic                   drd_rdy;
    logic                   dwr_req;
    cache_axi_pkg::wr_req_t dwr;
    logic                   dwr_rdy;
    logic                   iret_valid;
    cache_axi_pkg::ret_t    iret;
    logic                   dret_valid;
    cache_axi_pkg::ret_t    dret;
    logic                   test_done;
    logic [7:0]             test_idx;
    int                     pending;
    int                     checks;
    int                     errors;
    int                     cycles;
    int                     seed = 59765;
    test_row_t              rows [NUM_ROWS];

    cache_mem_top #(
        .MEM_WORDS (MEM_WORDS)
    ) UUT (
        .i_clock      (clock),
        .i_reset      (reset),
        .i_ird_req    (ird_req),
        .i_ird        (ird),
        .o_ird_rdy    (ird_rdy),
        .i_drd_req    (drd_req),
        .i_drd        (drd),
        .o_drd_rdy    (drd_rdy),
        .i_dwr_req    (dwr_req),
        .i_dwr        (dwr),
        .o_dwr_rdy    (dwr_rdy),
        .o_iret_valid (iret_valid),
        .o_iret       (iret),
        .o_dret_valid (dret_valid),
        .o_dret       (dret)
    );

    tb_checker #(
        .MEM_WORDS (MEM_WORDS)
    ) u_checker (
        .i_clock      (clock),
        .i_reset      (reset),
        .i_ird_req    (ird_req),
        .i_ird        (ird),
        .i_ird_rdy    (ird_rdy),
        .i_drd_req    (drd_req),
        .i_drd        (drd),
        .i_drd_rdy    (drd_rdy),
        .i_dwr_req    (dwr_req),
        .i_dwr        (dwr),
        .i_dwr_rdy    (dwr_rdy),
        .i_iret_valid (iret_valid),
        .i_iret       (iret),
        .i_dret_valid (dret_valid),
        .i_dret       (dret),
        .i_test_done  (test_done),
        .i_test_idx   (test_idx),
        .o_pending    (pending),
        .o_checks     (checks),
        .o_errors     (errors)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    function automatic logic [127:0] random_line();
        logic [127:0] line;
        for (int k = 0; k < 4; k++) line[32*k +: 32] = $random(seed);
        return line;
    endfunction

    task automatic launch_row(input test_row_t row);
        if (row.write) begin
            dwr_req <= 1'b1;
            dwr <= {row.rtype, row.addr, row.strb, row.data};
        end else begin
            if (row.client != DCACHE) begin
                ird_req <= 1'b1;
                ird <= (row.client == BOTH) ? {WORD, row.iaddr} : {row.rtype, row.addr};
            end
            if (row.client != ICACHE) begin
                drd_req <= 1'b1;
                drd <= {row.rtype, row.addr};
            end
        end
    endtask

    // hold each request until its ready strobe
    task automatic wait_accepts(input test_row_t row);
        logic need_i;
        logic need_d;
        logic need_w;
        need_w = row.write;
        need_i = !row.write && (row.client != DCACHE);
        need_d = !row.write && (row.client != ICACHE);
        while (need_i || need_d || need_w) begin
            @(posedge clock);
            if (need_i && ird_rdy) begin
                ird_req <= 1'b0;
                need_i = 1'b0;
            end
            if (need_d && drd_rdy) begin
                drd_req <= 1'b0;
                need_d = 1'b0;
            end
            if (need_w && dwr_rdy) begin
                dwr_req <= 1'b0;
                need_w = 1'b0;
            end
        end
    endtask

    task automatic close_test(input int idx);
        do @(posedge clock); while (pending != 0);
        test_done <= 1'b1;
        test_idx <= 8'(idx);
        @(posedge clock);
        test_done <= 1'b0;
    endtask

    initial begin
        reset = 1'b1;
        ird_req = 1'b0;
        ird = '0;
        drd_req = 1'b0;
        drd = '0;
        dwr_req = 1'b0;
        dwr = '0;
        test_done = 1'b0;
        test_idx = '0;
        rows[0] = '{ICACHE, 1'b0, WORD, 32'h40, 32'h0, 4'h0, 128'h0};
        rows[1] = '{DCACHE, 1'b0, LINE, 32'h80, 32'h0, 4'h0, 128'h0};
        rows[2] = '{BOTH, 1'b0, LINE, 32'h100, 32'h24, 4'h0, 128'h0};
        rows[3] = '{DCACHE, 1'b1, WORD, 32'h30, 32'h0, 4'b0101, 128'haabbccdd};
        rows[4] = '{DCACHE, 1'b0, WORD, 32'h30, 32'h0, 4'h0, 128'h0};
        rows[5] = '{DCACHE, 1'b1, LINE, 32'h200, 32'h0, 4'hf, random_line()};
        rows[6] = '{DCACHE, 1'b0, LINE, 32'h200, 32'h0, 4'h0, 128'h0};
        rows[7] = '{DCACHE, 1'b1, LINE, 32'h300, 32'h0, 4'hf, random_line()};
        rows[8] = '{ICACHE, 1'b0, WORD, 32'h308, 32'h0, 4'h0, 128'h0};  // lands mid burst
        rows[9] = '{DCACHE, 1'b0, LINE, 32'h300, 32'h0, 4'h0, 128'h0};
        repeat (4) @(posedge clock);
        reset <= 1'b0;
        @(posedge clock);
        for (int r = 0; r < NUM_ROWS; r++) begin
            launch_row(rows[r]);
            wait_accepts(rows[r]);
            close_test(r);
        end
        @(posedge clock);
        $display("tests %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, %0d return beats never arrived", cycles, pending);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial cycles = 0;

endmodule

`default_nettype wire

// ==== project.f ====
cache_axi_pkg.sv
bridge_ctrl.sv
rd_addr_issue.sv
rd_return_route.sv
wr_burst_unit.sv
axi_mem_model.sv
cache_mem_top.sv
tb_checker.sv
tb_cache_mem.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_cache_mem \
    -o tb_cache_mem > build.log 2>&1 \
    && ./obj_dir/tb_cache_mem > sim.log 2>&1 \
    || { echo "build or simulation did not complete, see build.log and sim.log"; exit 1; }
grep -q "RESULT: FAIL" sim.log \
    && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
